//--- alu_stage.sv
`default_nettype none
`timescale 1ns/1ns

module alu_stage (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               valid_i,
  input  core_pkg::alu_op_t  op_i,
  input  core_pkg::data_t    a_i,
  input  core_pkg::data_t    b_i,
  input  core_pkg::reg_idx_t rd_i,
  input  logic               hold_i,
  output logic               valid_o,
  output core_pkg::reg_idx_t rd_o,
  output core_pkg::data_t    result_o
);
  import core_pkg::*;

  logic     valid_q;
  alu_op_t  op_q;
  data_t    a_q;
  data_t    b_q;
  reg_idx_t rd_q;
  logic [SHAMT_WIDTH-1:0] shamt;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= 1'b0;
    end else if (!hold_i) begin
      valid_q <= valid_i;
    end
  end

  // Held instruction stays put until the write port is free
  always_ff @(posedge clk_i) begin
    if (!hold_i) begin
      op_q <= op_i;
      a_q  <= a_i;
      b_q  <= b_i;
      rd_q <= rd_i;
    end
  end

  assign shamt = b_q[SHAMT_WIDTH-1:0];

  always_comb begin
    case (op_q)
      ALU_ADD: result_o = a_q + b_q;
      ALU_SUB: result_o = a_q - b_q;
      ALU_AND: result_o = a_q & b_q;
      ALU_OR:  result_o = a_q | b_q;
      ALU_XOR: result_o = a_q ^ b_q;
      ALU_SLL: result_o = a_q << shamt;
      ALU_SRL: result_o = a_q >> shamt;
      default: result_o = '0;
    endcase
  end

  assign valid_o = valid_q;
  assign rd_o    = rd_q;

endmodule

`default_nettype wire

//--- core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int DATA_WIDTH    = 32;
  localparam int REG_COUNT     = 32;
  localparam int REG_IDX_WIDTH = 5;
  localparam int SHAMT_WIDTH   = 5;
  localparam int MUL_STAGES    = 5;

  // Major opcodes
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_SLL     = 3'b001;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_SRL     = 3'b101;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;
  localparam logic [2:0] FUNCT3_MUL     = 3'b000;

  localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
  localparam logic [6:0] FUNCT7_SUB    = 7'b0100000;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  typedef logic [DATA_WIDTH-1:0]    data_t;
  typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
  typedef logic [31:0]              instr_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL
  } alu_op_t;

endpackage

`default_nettype wire

//--- core_stimulus.txt
// Columns: instruction word, write-back expected (1/0), destination register, expected value
// All hex; first word is the number of entries
00000023
015A00B3 1 01 00000000  // ADD  x1, x20, x21
00500093 1 01 00000005  // ADDI x1, x0, 5
FFD00113 1 02 FFFFFFFD  // ADDI x2, x0, -3
002081B3 1 03 00000002  // ADD  x3, x1, x2
40208233 1 04 00000008  // SUB  x4, x1, x2
3F000293 1 05 000003F0  // ADDI x5, x0, 0x3f0
F0000313 1 06 FFFFFF00  // ADDI x6, x0, -256
0062F3B3 1 07 00000300  // AND  x7, x5, x6
0062E433 1 08 FFFFFFF0  // OR   x8, x5, x6
0062C4B3 1 09 FFFFFCF0  // XOR  x9, x5, x6
00509533 1 0A 00050000  // SLL  x10, x1, x5
001355B3 1 0B 07FFFFF8  // SRL  x11, x6, x1
00209633 1 0C A0000000  // SLL  x12, x1, x2
024086B3 1 0D 00000028  // MUL  x13, x1, x4
02110733 1 0E FFFFFFF1  // MUL  x14, x2, x1
022307B3 1 0F 00000300  // MUL  x15, x6, x2
02B58833 1 10 80000040  // MUL  x16, x11, x11
00E688B3 1 11 00000019  // ADD  x17, x13, x14
02388933 1 12 00000032  // MUL  x18, x17, x3
F9C90993 1 13 FFFFFFCE  // ADDI x19, x18, -100
02108A33 1 14 00000019  // MUL  x20, x1, x1
00408A33 1 14 0000000D  // ADD  x20, x1, x4
001A0A93 1 15 0000000E  // ADDI x21, x20, 1
02208B33 1 16 FFFFFFF1  // MUL  x22, x1, x2
0012CBB3 1 17 000003F5  // XOR  x23, x5, x1
0020EC33 1 18 FFFFFFFD  // OR   x24, x1, x2
40530EB3 1 1D FFFFFB10  // SUB  x29, x6, x5
00108033 0 00 00000000  // ADD  x0, x1, x1
00708013 0 00 00000000  // ADDI x0, x1, 7
02210033 0 00 00000000  // MUL  x0, x2, x2
12345CB7 0 19 00000000  // LUI  x25 (unsupported)
0220CD33 0 1A 00000000  // DIV  x26 (unsupported)
0FF0FD13 0 1A 00000000  // ANDI x26 (unsupported)
4020FCB3 0 19 00000000  // funct7 0x20 with funct3 7 (unsupported)
01AC8DB3 1 1B 00000000  // ADD  x27, x25, x26

//--- core_top.sv
`default_nettype none
`timescale 1ns/1ns

module core_top (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               instr_req_i,
  input  core_pkg::instr_t   instr_data_i,
  output logic               instr_ack_o,
  output logic               wb_valid_o,
  output core_pkg::reg_idx_t wb_reg_o,
  output core_pkg::data_t    wb_data_o
);
  import core_pkg::*;

  // Decode
  reg_idx_t dec_rs1;
  reg_idx_t dec_rs2;
  reg_idx_t dec_rd;
  logic     dec_valid;
  logic     dec_uses_rs2;
  data_t    rs1_data;
  data_t    rs2_data;
  logic     stall_issue;
  logic     alu_issue_valid;
  alu_op_t  alu_issue_op;
  logic     mul_issue_valid;
  data_t    op_a;
  data_t    op_b;

  // Execute
  logic     alu_valid;
  reg_idx_t alu_rd;
  data_t    alu_result;
  logic     alu_hold;
  logic [MUL_STAGES-1:0] mul_stage_valid;
  reg_idx_t mul_stage_rd [MUL_STAGES];
  logic     mul_valid;
  reg_idx_t mul_rd;
  data_t    mul_result;

  decode_stage decode_stage_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_req_i   (instr_req_i),
    .instr_data_i  (instr_data_i),
    .instr_ack_o   (instr_ack_o),
    .stall_issue_i (stall_issue),
    .rs1_o         (dec_rs1),
    .rs2_o         (dec_rs2),
    .rd_o          (dec_rd),
    .dec_valid_o   (dec_valid),
    .uses_rs2_o    (dec_uses_rs2),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .alu_valid_o   (alu_issue_valid),
    .alu_op_o      (alu_issue_op),
    .mul_valid_o   (mul_issue_valid),
    .op_a_o        (op_a),
    .op_b_o        (op_b)
  );

  rbank rbank_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wr_en_i     (wb_valid_o),
    .wr_reg_i    (wb_reg_o),
    .wr_data_i   (wb_data_o),
    .rd_reg_a_i  (dec_rs1),
    .rd_reg_b_i  (dec_rs2),
    .rd_data_a_o (rs1_data),
    .rd_data_b_o (rs2_data)
  );

  hazard_unit hazard_unit_i (
    .dec_valid_i    (dec_valid),
    .dec_uses_rs2_i (dec_uses_rs2),
    .dec_rs1_i      (dec_rs1),
    .dec_rs2_i      (dec_rs2),
    .dec_rd_i       (dec_rd),
    .alu_valid_i    (alu_valid),
    .alu_rd_i       (alu_rd),
    .alu_hold_i     (alu_hold),
    .mul_valid_i    (mul_stage_valid),
    .mul_rd_i       (mul_stage_rd),
    .stall_issue_o  (stall_issue)
  );

  alu_stage alu_stage_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .valid_i  (alu_issue_valid),
    .op_i     (alu_issue_op),
    .a_i      (op_a),
    .b_i      (op_b),
    .rd_i     (dec_rd),
    .hold_i   (alu_hold),
    .valid_o  (alu_valid),
    .rd_o     (alu_rd),
    .result_o (alu_result)
  );

  mul_pipe mul_pipe_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .valid_i       (mul_issue_valid),
    .a_i           (op_a),
    .b_i           (op_b),
    .rd_i          (dec_rd),
    .stage_valid_o (mul_stage_valid),
    .stage_rd_o    (mul_stage_rd),
    .valid_o       (mul_valid),
    .rd_o          (mul_rd),
    .result_o      (mul_result)
  );

  wb_arbiter wb_arbiter_i (
    .alu_valid_i  (alu_valid),
    .alu_rd_i     (alu_rd),
    .alu_result_i (alu_result),
    .mul_valid_i  (mul_valid),
    .mul_rd_i     (mul_rd),
    .mul_result_i (mul_result),
    .wr_en_o      (wb_valid_o),
    .wr_reg_o     (wb_reg_o),
    .wr_data_o    (wb_data_o),
    .alu_hold_o   (alu_hold)
  );

endmodule

`default_nettype wire

//--- decode_stage.sv
`default_nettype none
`timescale 1ns/1ns

module decode_stage (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               instr_req_i,
  input  core_pkg::instr_t   instr_data_i,
  output logic               instr_ack_o,
  input  logic               stall_issue_i,
  output core_pkg::reg_idx_t rs1_o,
  output core_pkg::reg_idx_t rs2_o,
  output core_pkg::reg_idx_t rd_o,
  output logic               dec_valid_o,
  output logic               uses_rs2_o,
  input  core_pkg::data_t    rs1_data_i,
  input  core_pkg::data_t    rs2_data_i,
  output logic               alu_valid_o,
  output core_pkg::alu_op_t  alu_op_o,
  output logic               mul_valid_o,
  output core_pkg::data_t    op_a_o,
  output core_pkg::data_t    op_b_o
);
  import core_pkg::*;

  typedef enum logic {HS_IDLE, HS_ACK} hs_state_t;

  hs_state_t  hs_state_q;
  logic       capture;
  logic       cap_valid_q;
  instr_t     cap_instr_q;
  logic       dec_advance;
  logic       dec_valid_q;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_alu;
  logic       is_mul;
  logic       uses_rs2;
  alu_op_t    op;
  data_t      imm;

  logic       dec_is_alu_q;
  logic       dec_is_mul_q;
  logic       dec_uses_rs2_q;
  alu_op_t    dec_op_q;
  reg_idx_t   dec_rs1_q;
  reg_idx_t   dec_rs2_q;
  reg_idx_t   dec_rd_q;
  data_t      dec_imm_q;

  // Word is taken only in a cycle where the decode register can move
  assign capture     = (hs_state_q == HS_IDLE) && instr_req_i && !stall_issue_i;
  assign dec_advance = !dec_valid_q || !stall_issue_i;
  assign instr_ack_o = (hs_state_q == HS_ACK);

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      hs_state_q  <= HS_IDLE;
      cap_valid_q <= 1'b0;
      dec_valid_q <= 1'b0;
    end else begin
      if (hs_state_q == HS_IDLE) begin
        if (capture) begin
          hs_state_q <= HS_ACK;
        end
      end else if (!instr_req_i) begin
        hs_state_q <= HS_IDLE;
      end
      if (capture) begin
        cap_valid_q <= 1'b1;
      end else if (dec_advance) begin
        cap_valid_q <= 1'b0;
      end
      if (dec_advance) begin
        dec_valid_q <= cap_valid_q;
      end
    end
  end

  assign opcode = cap_instr_q[6:0];
  assign funct3 = cap_instr_q[14:12];
  assign funct7 = cap_instr_q[31:25];
  assign imm    = {{20{cap_instr_q[31]}}, cap_instr_q[31:20]};

  always_comb begin
    is_alu   = 1'b0;
    is_mul   = 1'b0;
    uses_rs2 = 1'b1;
    op       = ALU_ADD;
    if (opcode == OPCODE_OP) begin
      if (funct7 == FUNCT7_MULDIV) begin
        is_mul = (funct3 == FUNCT3_MUL);
      end else if (funct7 == FUNCT7_SUB) begin
        is_alu = (funct3 == FUNCT3_ADD_SUB);
        op     = ALU_SUB;
      end else if (funct7 == FUNCT7_BASE) begin
        is_alu = 1'b1;
        case (funct3)
          FUNCT3_ADD_SUB: op = ALU_ADD;
          FUNCT3_SLL:     op = ALU_SLL;
          FUNCT3_XOR:     op = ALU_XOR;
          FUNCT3_SRL:     op = ALU_SRL;
          FUNCT3_OR:      op = ALU_OR;
          FUNCT3_AND:     op = ALU_AND;
          default:        is_alu = 1'b0;
        endcase
      end
    end else if (opcode == OPCODE_OP_IMM) begin
      // Only ADDI
      uses_rs2 = 1'b0;
      is_alu   = (funct3 == FUNCT3_ADD_SUB);
    end
    // Writes to x0 retire silently
    if (cap_instr_q[11:7] == '0) begin
      is_alu = 1'b0;
      is_mul = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      cap_instr_q <= instr_data_i;
    end
    if (dec_advance) begin
      dec_is_alu_q   <= is_alu;
      dec_is_mul_q   <= is_mul;
      dec_uses_rs2_q <= uses_rs2;
      dec_op_q       <= op;
      dec_rs1_q      <= cap_instr_q[19:15];
      dec_rs2_q      <= cap_instr_q[24:20];
      dec_rd_q       <= cap_instr_q[11:7];
      dec_imm_q      <= imm;
    end
  end

  assign rs1_o       = dec_rs1_q;
  assign rs2_o       = dec_rs2_q;
  assign rd_o        = dec_rd_q;
  assign uses_rs2_o  = dec_uses_rs2_q;
  assign dec_valid_o = dec_valid_q && (dec_is_alu_q || dec_is_mul_q);

  assign alu_valid_o = dec_valid_q && dec_is_alu_q && !stall_issue_i;
  assign mul_valid_o = dec_valid_q && dec_is_mul_q && !stall_issue_i;
  assign alu_op_o    = dec_op_q;
  assign op_a_o      = rs1_data_i;
  assign op_b_o      = dec_uses_rs2_q ? rs2_data_i : dec_imm_q;

endmodule

`default_nettype wire

//--- hazard_unit.sv
`default_nettype none
`timescale 1ns/1ns

module hazard_unit (
  input  logic                               dec_valid_i,
  input  logic                               dec_uses_rs2_i,
  input  core_pkg::reg_idx_t                 dec_rs1_i,
  input  core_pkg::reg_idx_t                 dec_rs2_i,
  input  core_pkg::reg_idx_t                 dec_rd_i,
  input  logic                               alu_valid_i,
  input  core_pkg::reg_idx_t                 alu_rd_i,
  input  logic                               alu_hold_i,
  input  logic [core_pkg::MUL_STAGES-1:0]    mul_valid_i,
  input  core_pkg::reg_idx_t                 mul_rd_i [core_pkg::MUL_STAGES],
  output logic                               stall_issue_o
);
  import core_pkg::*;

  logic                  alu_hit;
  logic [MUL_STAGES-1:0] mul_hit;

  // True when the decoded instruction reads or writes idx
  function automatic logic touches(reg_idx_t idx);
    logic rs2_hit;
    rs2_hit = dec_uses_rs2_i && (dec_rs2_i == idx);
    return (dec_rs1_i == idx) || rs2_hit || (dec_rd_i == idx);
  endfunction

  always_comb begin
    alu_hit = alu_valid_i && touches(alu_rd_i);
    for (int s = 0; s < MUL_STAGES; s++) begin
      mul_hit[s] = mul_valid_i[s] && touches(mul_rd_i[s]);
    end
  end

  // RAW and WAW both wait for the producer to write back
  assign stall_issue_o = alu_hold_i || (dec_valid_i && (alu_hit || (|mul_hit)));

endmodule

`default_nettype wire

//--- mul_pipe.sv
`default_nettype none
`timescale 1ns/1ns

module mul_pipe (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            valid_i,
  input  core_pkg::data_t                 a_i,
  input  core_pkg::data_t                 b_i,
  input  core_pkg::reg_idx_t              rd_i,
  output logic [core_pkg::MUL_STAGES-1:0] stage_valid_o,
  output core_pkg::reg_idx_t              stage_rd_o [core_pkg::MUL_STAGES],
  output logic                            valid_o,
  output core_pkg::reg_idx_t              rd_o,
  output core_pkg::data_t                 result_o
);
  import core_pkg::*;

  logic [MUL_STAGES-1:0] valid_q;
  reg_idx_t              rd_q [MUL_STAGES];
  logic [31:0]           pp_ll_q;
  logic [15:0]           pp_lh_q;
  logic [15:0]           pp_hl_q;
  data_t                 res_q [1:MUL_STAGES-1];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[MUL_STAGES-2:0], valid_i};
    end
  end

  always_ff @(posedge clk_i) begin
    rd_q[0] <= rd_i;
    for (int s = 1; s < MUL_STAGES; s++) begin
      rd_q[s] <= rd_q[s-1];
    end
    // Upper cross terms only reach bits above 31
    pp_ll_q <= a_i[15:0] * b_i[15:0];
    pp_lh_q <= a_i[15:0] * b_i[31:16];
    pp_hl_q <= a_i[31:16] * b_i[15:0];
    res_q[1] <= pp_ll_q + {pp_lh_q + pp_hl_q, 16'h0000};
    for (int s = 2; s < MUL_STAGES; s++) begin
      res_q[s] <= res_q[s-1];
    end
  end

  assign stage_valid_o = valid_q;
  assign stage_rd_o    = rd_q;
  assign valid_o       = valid_q[MUL_STAGES-1];
  assign rd_o          = rd_q[MUL_STAGES-1];
  assign result_o      = res_q[MUL_STAGES-1];

endmodule

`default_nettype wire

//--- rbank.sv
`default_nettype none
`timescale 1ns/1ns

module rbank (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               wr_en_i,
  input  core_pkg::reg_idx_t wr_reg_i,
  input  core_pkg::data_t    wr_data_i,
  input  core_pkg::reg_idx_t rd_reg_a_i,
  input  core_pkg::reg_idx_t rd_reg_b_i,
  output core_pkg::data_t    rd_data_a_o,
  output core_pkg::data_t    rd_data_b_o
);
  import core_pkg::*;

  data_t regs_q [REG_COUNT];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && (wr_reg_i != '0)) begin
      regs_q[wr_reg_i] <= wr_data_i;
    end
  end

  // x0 is hardwired to zero
  assign rd_data_a_o = (rd_reg_a_i == '0) ? '0 : regs_q[rd_reg_a_i];
  assign rd_data_b_o = (rd_reg_b_i == '0) ? '0 : regs_q[rd_reg_b_i];

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_core -f sources.f \
  && ./obj_dir/Vtb_core | tee sim.log

grep -q "Simulation completed successfully" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

//--- sources.f
core_pkg.sv
rbank.sv
hazard_unit.sv
decode_stage.sv
alu_stage.sv
mul_pipe.sv
wb_arbiter.sv
core_top.sv
tb_core.sv

//--- tb_core.sv
`default_nettype none
`timescale 1ns/1ns

module tb_core;
  import core_pkg::*;

  localparam int MAX_ENTRIES   = 64;
  localparam int HS_TIMEOUT    = 200;
  localparam int DRAIN_TIMEOUT = 500;

  logic        clk_i;
  logic        rst_i;
  logic        instr_req_i;
  instr_t      instr_data_i;
  logic        instr_ack_o;
  logic        wb_valid_o;
  reg_idx_t    wb_reg_o;
  data_t       wb_data_o;

  // Word 0 is the entry count, then four words per entry
  logic [31:0] stim_mem [0:4*MAX_ENTRIES];
  int          num_entries;
  reg_idx_t    exp_reg_q [$];
  data_t       exp_data_q [$];
  logic [31:0] lcg_state;

  core_top core_top_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .instr_req_i  (instr_req_i),
    .instr_data_i (instr_data_i),
    .instr_ack_o  (instr_ack_o),
    .wb_valid_o   (wb_valid_o),
    .wb_reg_o     (wb_reg_o),
    .wb_data_o    (wb_data_o)
  );

  always #10 clk_i = ~clk_i;

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_wb_reg(input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Fail at %0t ns: wb_reg_o = x%0d, expected x%0d",
                                  $time, got, exp));
    end
  endtask

  task automatic check_wb_data(input data_t got, input data_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Fail at %0t ns: wb_data_o = %08h, expected %08h",
                                  $time, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Fail at %0t ns: %s = %b, expected %b",
                                  $time, name, got, exp));
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Four-phase transfer of one instruction word
  task automatic send_instr(input instr_t word);
    int waited;
    @(posedge clk_i);
    instr_req_i  <= 1'b1;
    instr_data_i <= word;
    waited = 0;
    @(negedge clk_i);
    while (instr_ack_o !== 1'b1) begin
      if (waited == HS_TIMEOUT) begin
        stop_with_failure($sformatf("Timeout: no ack for instruction %08h", word));
      end
      waited++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    instr_req_i <= 1'b0;
    waited = 0;
    @(negedge clk_i);
    while (instr_ack_o !== 1'b0) begin
      if (waited == HS_TIMEOUT) begin
        stop_with_failure("Timeout: ack stayed high after the request was dropped");
      end
      waited++;
      @(negedge clk_i);
    end
  endtask

  // Oldest outstanding entry for the same register must match
  always @(negedge clk_i) begin : monitor
    int match;
    if (rst_i && wb_valid_o) begin
      match = -1;
      for (int k = 0; k < exp_reg_q.size(); k++) begin
        if ((match < 0) && (exp_reg_q[k] == wb_reg_o)) begin
          match = k;
        end
      end
      if (exp_reg_q.size() == 0) begin
        stop_with_failure($sformatf("Write-back to x%0d at %0t ns when none was expected",
                                    wb_reg_o, $time));
      end else if (match < 0) begin
        check_wb_reg(wb_reg_o, exp_reg_q[0]);
      end else begin
        check_wb_data(wb_data_o, exp_data_q[match]);
        exp_reg_q.delete(match);
        exp_data_q.delete(match);
      end
    end
  end

  initial begin
    int          base;
    int          waited;
    logic [1:0]  gap;
    clk_i        = 1'b0;
    rst_i        = 1'b0;
    instr_req_i  = 1'b0;
    instr_data_i = '0;
    lcg_state    = 32'h8c0;
    $readmemh("core_stimulus.txt", stim_mem);
    num_entries = int'(stim_mem[0]);
    if ((num_entries == 0) || (num_entries > MAX_ENTRIES)) begin
      stop_with_failure("Stimulus file holds no usable entry count");
    end
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b1;
    @(negedge clk_i);
    check_flag("instr_ack_o", instr_ack_o, 1'b0);
    check_flag("wb_valid_o", wb_valid_o, 1'b0);

    for (int i = 0; i < num_entries; i++) begin
      base = 1 + 4 * i;
      if (stim_mem[base+1][0]) begin
        exp_reg_q.push_back(stim_mem[base+2][REG_IDX_WIDTH-1:0]);
        exp_data_q.push_back(stim_mem[base+3]);
      end
      send_instr(stim_mem[base]);
      lcg_state = lcg_next(lcg_state);
      gap = lcg_state[17:16];
      repeat (gap) @(posedge clk_i);
    end

    waited = 0;
    while (exp_reg_q.size() != 0) begin
      if (waited == DRAIN_TIMEOUT) begin
        stop_with_failure($sformatf("Timeout: %0d write-backs never arrived",
                                    exp_reg_q.size()));
      end
      waited++;
      @(negedge clk_i);
    end
    // Room for any stray write-back to show up
    repeat (12) @(negedge clk_i);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- wb_arbiter.sv
`default_nettype none
`timescale 1ns/1ns

module wb_arbiter (
  input  logic               alu_valid_i,
  input  core_pkg::reg_idx_t alu_rd_i,
  input  core_pkg::data_t    alu_result_i,
  input  logic               mul_valid_i,
  input  core_pkg::reg_idx_t mul_rd_i,
  input  core_pkg::data_t    mul_result_i,
  output logic               wr_en_o,
  output core_pkg::reg_idx_t wr_reg_o,
  output core_pkg::data_t    wr_data_o,
  output logic               alu_hold_o
);

  // Multiply pipe cannot stall, so it always wins
  assign wr_en_o    = mul_valid_i || alu_valid_i;
  assign wr_reg_o   = mul_valid_i ? mul_rd_i : alu_rd_i;
  assign wr_data_o  = mul_valid_i ? mul_result_i : alu_result_i;
  assign alu_hold_o = mul_valid_i && alu_valid_i;

endmodule

`default_nettype wire
